// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_conv
FILELIST  = build.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
src/conv_pkg.sv
src/conv_line_buffer.sv
src/conv_frame_position.sv
src/conv_window.sv
src/conv_top.sv
tests/conv_checker.sv
tests/tb_conv.sv

// ==== src/conv_frame_position.sv ====
`timescale 1ns/1ps

module conv_frame_position #(
    parameter int LINE_WIDTH = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic i_valid,
    output logic o_win_full
);

    localparam int CNT_W = (LINE_WIDTH > 2) ? $clog2(LINE_WIDTH) : 2;
    localparam logic [CNT_W-1:0] LAST_COL = CNT_W'(LINE_WIDTH - 1);
    localparam logic [CNT_W-1:0] FIRST_FULL = CNT_W'(conv_pkg::WIN_N - 1);

    logic [CNT_W-1:0] col_cnt;
    // saturates at 2 as only row 2 or more matters
    logic [1:0]       row_cnt;
    logic             win_ok;

    // window complete once both counts reach 2
    assign win_ok = (col_cnt >= FIRST_FULL) && (row_cnt == 2'd2);

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_valid) begin
            if (col_cnt == LAST_COL) begin
                col_cnt <= '0;
                if (row_cnt != 2'd2) begin
                    row_cnt <= row_cnt + 2'd1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // lines up with the line buffer column strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            o_win_full <= 1'b0;
        end else begin
            o_win_full <= i_valid & win_ok;
        end
    end

endmodule

// ==== src/conv_line_buffer.sv ====
`timescale 1ns/1ps

module conv_line_buffer #(
    parameter int LINE_WIDTH = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_pixel,
    output logic signed [conv_pkg::PIXEL_W-1:0] o_col_top,
    output logic signed [conv_pkg::PIXEL_W-1:0] o_col_mid,
    output logic signed [conv_pkg::PIXEL_W-1:0] o_col_bot,
    output logic                                o_col_valid
);

    // row stores with the newest pixel at index 0
    logic signed [conv_pkg::PIXEL_W-1:0] row_near [LINE_WIDTH];
    logic signed [conv_pkg::PIXEL_W-1:0] row_far  [LINE_WIDTH];

    // oldest entries are the pixels one and two rows up
    logic signed [conv_pkg::PIXEL_W-1:0] one_up;
    logic signed [conv_pkg::PIXEL_W-1:0] two_up;

    assign one_up = row_near[LINE_WIDTH-1];
    assign two_up = row_far[LINE_WIDTH-1];

    // shift both stores on every pixel strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LINE_WIDTH; i++) begin
                row_near[i] <= '0;
                row_far[i]  <= '0;
            end
        end else if (i_valid) begin
            row_near[0] <= i_pixel;
            row_far[0]  <= one_up;
            for (int i = 1; i < LINE_WIDTH; i++) begin
                row_near[i] <= row_near[i-1];
                row_far[i]  <= row_far[i-1];
            end
        end
    end

    // column output taken before the stores move
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_col_top <= two_up;
            o_col_mid <= one_up;
            o_col_bot <= i_pixel;
        end
    end

    // strobe follows the pixel by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            o_col_valid <= 1'b0;
        end else begin
            o_col_valid <= i_valid;
        end
    end

endmodule

// ==== src/conv_pkg.sv ====
package conv_pkg;

    // signed width of a pixel or a kernel weight
    parameter int PIXEL_W = 8;

    // window is WIN_N x WIN_N
    parameter int WIN_N = 3;

    // one window column packed as {top, mid, bot}
    parameter int COL_W = WIN_N * PIXEL_W;

    // nine 8x8 signed products need 19 bits plus one of margin
    parameter int ACC_W = 20;

    // offset-binary output width
    parameter int OUT_W = 13;

    // default kernel is a scaled laplacian
    //   0   32   0
    //  32 -128  32
    //   0   32   0
    // column words are {top, mid, bot} with index 0 as the oldest column
    parameter logic [WIN_N-1:0][COL_W-1:0] RESET_KERNEL = {
        24'h00_20_00,
        24'h20_80_20,
        24'h00_20_00
    };

endpackage

// ==== src/conv_top.sv ====
`timescale 1ns/1ps

module conv_top #(
    parameter int LINE_WIDTH = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  logic                                i_kernel_mode,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_pixel,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_k_top,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_k_mid,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_k_bot,
    output logic        [conv_pkg::OUT_W-1:0]   o_data,
    output logic                                o_valid
);

    logic                                pix_valid;
    logic signed [conv_pkg::PIXEL_W-1:0] col_top;
    logic signed [conv_pkg::PIXEL_W-1:0] col_mid;
    logic signed [conv_pkg::PIXEL_W-1:0] col_bot;
    logic                                col_valid;
    logic                                win_full;

    // kernel path delayed to match the line buffer register
    logic                                mode_q;
    logic                                k_valid_q;
    logic signed [conv_pkg::PIXEL_W-1:0] k_top_q;
    logic signed [conv_pkg::PIXEL_W-1:0] k_mid_q;
    logic signed [conv_pkg::PIXEL_W-1:0] k_bot_q;

    // window column select
    logic                                win_valid;
    logic signed [conv_pkg::PIXEL_W-1:0] win_top;
    logic signed [conv_pkg::PIXEL_W-1:0] win_mid;
    logic signed [conv_pkg::PIXEL_W-1:0] win_bot;

    assign pix_valid = i_valid & ~i_kernel_mode;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q    <= 1'b0;
            k_valid_q <= 1'b0;
        end else begin
            mode_q    <= i_kernel_mode;
            k_valid_q <= i_valid & i_kernel_mode;
        end
    end

    always_ff @(posedge clk) begin
        k_top_q <= i_k_top;
        k_mid_q <= i_k_mid;
        k_bot_q <= i_k_bot;
    end

    assign win_valid = col_valid | k_valid_q;
    assign win_top   = mode_q ? k_top_q : col_top;
    assign win_mid   = mode_q ? k_mid_q : col_mid;
    assign win_bot   = mode_q ? k_bot_q : col_bot;

    conv_line_buffer #(
        .LINE_WIDTH (LINE_WIDTH)
    ) u_line_buffer (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (pix_valid),
        .i_pixel     (i_pixel),
        .o_col_top   (col_top),
        .o_col_mid   (col_mid),
        .o_col_bot   (col_bot),
        .o_col_valid (col_valid)
    );

    conv_frame_position #(
        .LINE_WIDTH (LINE_WIDTH)
    ) u_frame_position (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (pix_valid),
        .o_win_full (win_full)
    );

    conv_window u_window (
        .clk           (clk),
        .rst           (rst),
        .i_valid       (win_valid),
        .i_kernel_mode (mode_q),
        .i_col_top     (win_top),
        .i_col_mid     (win_mid),
        .i_col_bot     (win_bot),
        .i_win_full    (win_full),
        .o_data        (o_data),
        .o_valid       (o_valid)
    );

endmodule

// ==== src/conv_window.sv ====
`timescale 1ns/1ps

module conv_window (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  logic                                i_kernel_mode,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_col_top,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_col_mid,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_col_bot,
    input  logic                                i_win_full,
    output logic        [conv_pkg::OUT_W-1:0]   o_data,
    output logic                                o_valid
);

    localparam int PW = conv_pkg::PIXEL_W;
    localparam int N = conv_pkg::WIN_N;
    localparam int AW = conv_pkg::ACC_W;
    localparam int OW = conv_pkg::OUT_W;

    // {top, mid, bot} column words with the newest at index N-1
    logic [conv_pkg::COL_W-1:0] kernel [N];
    logic [conv_pkg::COL_W-1:0] image  [N];

    // image window as it looks after this strobe
    logic [conv_pkg::COL_W-1:0] next_image [N];

    logic [conv_pkg::COL_W-1:0] in_col;
    logic                       kernel_shift;
    logic                       image_shift;
    logic signed [AW-1:0]       sum;
    logic signed [AW-1:0]       acc;

    assign in_col       = {i_col_top, i_col_mid, i_col_bot};
    assign kernel_shift = i_valid & i_kernel_mode;
    assign image_shift  = i_valid & ~i_kernel_mode;

    always_comb begin
        for (int c = 0; c < N - 1; c++) begin
            next_image[c] = image[c+1];
        end
        next_image[N-1] = in_col;
    end

    // nine-term signed multiply-accumulate
    always_comb begin
        sum = '0;
        for (int c = 0; c < N; c++) begin
            for (int r = 0; r < N; r++) begin
                sum = sum + $signed(kernel[c][r*PW +: PW]) *
                            $signed(next_image[c][r*PW +: PW]);
            end
        end
    end

    // kernel and image column shift registers
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < N; c++) begin
                kernel[c] <= conv_pkg::RESET_KERNEL[c];
                image[c]  <= '0;
            end
        end else if (kernel_shift) begin
            for (int c = 0; c < N - 1; c++) begin
                kernel[c] <= kernel[c+1];
            end
            kernel[N-1] <= in_col;
        end else if (image_shift) begin
            for (int c = 0; c < N; c++) begin
                image[c] <= next_image[c];
            end
        end
    end

    // sum only moves on image strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            acc     <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= image_shift & i_win_full;
            if (image_shift) begin
                acc <= sum;
            end
        end
    end

    // offset binary with inverted sign over bits 18..7
    assign o_data = {~acc[AW-1], acc[AW-2 -: OW-1]};

endmodule

// ==== tests/conv_checker.sv ====
`timescale 1ns/1ps

module conv_checker #(
    parameter int LINE_WIDTH = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_valid,
    input  logic                                i_kernel_mode,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_pixel,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_k_top,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_k_mid,
    input  logic signed [conv_pkg::PIXEL_W-1:0] i_k_bot,
    input  logic        [conv_pkg::OUT_W-1:0]   i_data,
    input  logic                                i_out_valid,
    output int                                  o_error_count,
    output int                                  o_check_count
);

    // weights by column (0 is the oldest) and row (0 is the top)
    int weight [3][3];
    // every pixel strobe since reset in stream order
    int history [$];
    int col_pos;
    int row_pos;

    // expected outputs one and two cycles behind the sampled input
    logic [conv_pkg::OUT_W-1:0] exp_data_1;
    logic [conv_pkg::OUT_W-1:0] exp_data_2;
    logic                       exp_valid_1;
    logic                       exp_valid_2;

    int error_count = 0;
    int check_count = 0;

    assign o_error_count = error_count;
    assign o_check_count = check_count;

    // offset binary with inverted sign, then bits 18 down to 7
    function automatic logic [conv_pkg::OUT_W-1:0] format_sum(input int s);
        logic [conv_pkg::ACC_W-1:0] a;
        a = conv_pkg::ACC_W'(s);
        return {~a[19], a[18:7]};
    endfunction

    function automatic int pixel_at(input int idx);
        if (idx < 0) begin
            return 0;
        end
        return history[idx];
    endfunction

    // three newest columns over the current row and the two above it
    function automatic int window_sum();
        int n;
        int p;
        int s;
        n = history.size() - 1;
        s = 0;
        for (int c = 0; c < 3; c++) begin
            p = n - 2 + c;
            s += weight[c][0] * pixel_at(p - 2 * LINE_WIDTH);
            s += weight[c][1] * pixel_at(p - LINE_WIDTH);
            s += weight[c][2] * pixel_at(p);
        end
        return s;
    endfunction

    task automatic clear_model();
        history.delete();
        col_pos = 0;
        row_pos = 0;
        // laplacian with 32 around a -128 centre
        weight[0] = '{0, 32, 0};
        weight[1] = '{32, -128, 32};
        weight[2] = '{0, 32, 0};
        exp_data_1  = format_sum(0);
        exp_data_2  = format_sum(0);
        exp_valid_1 = 1'b0;
        exp_valid_2 = 1'b0;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            clear_model();
        end else begin
            exp_data_2  = exp_data_1;
            exp_valid_2 = exp_valid_1;
            exp_valid_1 = 1'b0;
            if (i_valid && i_kernel_mode) begin
                weight[0] = weight[1];
                weight[1] = weight[2];
                weight[2] = '{int'(i_k_top), int'(i_k_mid), int'(i_k_bot)};
            end else if (i_valid) begin
                history.push_back(int'(i_pixel));
                exp_data_1  = format_sum(window_sum());
                exp_valid_1 = (col_pos >= 2) && (row_pos >= 2);
                if (col_pos == LINE_WIDTH - 1) begin
                    col_pos = 0;
                    row_pos++;
                end else begin
                    col_pos++;
                end
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_count++;
            if (i_out_valid !== exp_valid_2) begin
                error_count++;
                $display("ERR %0t o_valid expected %0b got %0b",
                         $time, exp_valid_2, i_out_valid);
            end
            if (i_data !== exp_data_2) begin
                error_count++;
                $display("ERR %0t o_data expected %h got %h",
                         $time, exp_data_2, i_data);
            end
        end
    end

endmodule

// ==== tests/tb_conv.sv ====
`timescale 1ns/1ps

module tb_conv;

    localparam int LINE_WIDTH = 8;
    localparam int FRAME_ROWS = 6;
    localparam int TABLE_MAX = 256;

    logic                                clk;
    logic                                rst;
    logic                                i_valid;
    logic                                i_kernel_mode;
    logic signed [conv_pkg::PIXEL_W-1:0] i_pixel;
    logic signed [conv_pkg::PIXEL_W-1:0] i_k_top;
    logic signed [conv_pkg::PIXEL_W-1:0] i_k_mid;
    logic signed [conv_pkg::PIXEL_W-1:0] i_k_bot;
    logic        [conv_pkg::OUT_W-1:0]   o_data;
    logic                                o_valid;

    // stimulus table with one entry per cycle
    logic                                tab_mode  [TABLE_MAX];
    logic                                tab_valid [TABLE_MAX];
    logic signed [conv_pkg::PIXEL_W-1:0] tab_pix   [TABLE_MAX];
    logic signed [conv_pkg::PIXEL_W-1:0] tab_kt    [TABLE_MAX];
    logic signed [conv_pkg::PIXEL_W-1:0] tab_km    [TABLE_MAX];
    logic signed [conv_pkg::PIXEL_W-1:0] tab_kb    [TABLE_MAX];
    int tab_len = 0;

    int cycle_count = 0;
    int error_count;
    int check_count;

    conv_top #(
        .LINE_WIDTH (LINE_WIDTH)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .i_valid       (i_valid),
        .i_kernel_mode (i_kernel_mode),
        .i_pixel       (i_pixel),
        .i_k_top       (i_k_top),
        .i_k_mid       (i_k_mid),
        .i_k_bot       (i_k_bot),
        .o_data        (o_data),
        .o_valid       (o_valid)
    );

    conv_checker #(
        .LINE_WIDTH (LINE_WIDTH)
    ) u_checker (
        .clk           (clk),
        .rst           (rst),
        .i_valid       (i_valid),
        .i_kernel_mode (i_kernel_mode),
        .i_pixel       (i_pixel),
        .i_k_top       (i_k_top),
        .i_k_mid       (i_k_mid),
        .i_k_bot       (i_k_bot),
        .i_data        (o_data),
        .i_out_valid   (o_valid),
        .o_error_count (error_count),
        .o_check_count (check_count)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic add_entry(input logic mode, input logic valid, input logic [7:0] pix,
                             input logic [7:0] kt, input logic [7:0] km,
                             input logic [7:0] kb);
        tab_mode[tab_len]  = mode;
        tab_valid[tab_len] = valid;
        tab_pix[tab_len]   = pix;
        tab_kt[tab_len]    = kt;
        tab_km[tab_len]    = km;
        tab_kb[tab_len]    = kb;
        tab_len++;
    endtask

    // idle cycles carry junk data that must be ignored
    task automatic insert_idle(input int n);
        for (int i = 0; i < n; i++) begin
            add_entry(1'b0, 1'b0, 8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom));
        end
    endtask

    task automatic load_kernel_col(input logic [7:0] kt, input logic [7:0] km,
                                   input logic [7:0] kb);
        add_entry(1'b1, 1'b1, 8'($urandom), kt, km, kb);
    endtask

    task automatic queue_frame(input bit with_gaps, input bit fixed, input logic [7:0] value);
        for (int r = 0; r < FRAME_ROWS; r++) begin
            for (int c = 0; c < LINE_WIDTH; c++) begin
                // stall mid-row on odd rows
                if (with_gaps && c == 4 && r % 2 == 1) begin
                    insert_idle(2);
                end
                add_entry(1'b0, 1'b1, fixed ? value : 8'($urandom), 8'($urandom),
                          8'($urandom), 8'($urandom));
            end
        end
    endtask

    task automatic build_table();
        insert_idle(6);
        queue_frame(1'b1, 1'b0, 8'h00);
        insert_idle(4);
        // random kernel with a kernel-mode idle in between
        load_kernel_col(8'($urandom), 8'($urandom), 8'($urandom));
        add_entry(1'b1, 1'b0, 8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom));
        load_kernel_col(8'($urandom), 8'($urandom), 8'($urandom));
        load_kernel_col(8'($urandom), 8'($urandom), 8'($urandom));
        queue_frame(1'b1, 1'b0, 8'h00);
        // extremes give the largest sums of both signs
        load_kernel_col(8'h80, 8'h80, 8'h80);
        load_kernel_col(8'h80, 8'h80, 8'h80);
        load_kernel_col(8'h80, 8'h80, 8'h80);
        queue_frame(1'b0, 1'b1, 8'h80);
        load_kernel_col(8'h7f, 8'h7f, 8'h7f);
        load_kernel_col(8'h7f, 8'h7f, 8'h7f);
        load_kernel_col(8'h7f, 8'h7f, 8'h7f);
        queue_frame(1'b0, 1'b1, 8'h80);
        insert_idle(6);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 2 * tab_len + 50) begin
            $display("timeout: run did not end within %0d cycles", 2 * tab_len + 50);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h0d13_442e));
        rst = 1'b1;
        i_valid = 1'b0;
        i_kernel_mode = 1'b0;
        i_pixel = '0;
        i_k_top = '0;
        i_k_mid = '0;
        i_k_bot = '0;
        build_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < tab_len; i++) begin
            @(posedge clk);
            #1;
            i_kernel_mode = tab_mode[i];
            i_valid = tab_valid[i];
            i_pixel = tab_pix[i];
            i_k_top = tab_kt[i];
            i_k_mid = tab_km[i];
            i_k_bot = tab_kb[i];
        end
        @(posedge clk);
        #1;
        i_valid = 1'b0;
        i_kernel_mode = 1'b0;
        // two-cycle pipeline drains before the last compare
        repeat (3) @(posedge clk);
        @(negedge clk);
        #1;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
